// File: hdl/alu_params.svh
`ifndef ALU_PARAMS_SVH
`define ALU_PARAMS_SVH

// operand width and derived shift amount width
`define ALU_WIDTH 32
`define ALU_SHAMT_W 5

// buffering between pipeline blocks
`define ALU_FIFO_DEPTH 4

// command field widths
`define ALU_UNIT_W 2
`define ALU_FUNC_W 3

// decoded operation code width
`define ALU_OP_W 5

`endif

// File: hdl/alu_pkg.sv
`default_nettype none

`include "alu_params.svh"

package alu_pkg;

    // top level unit select
    typedef enum logic [`ALU_UNIT_W-1:0] {
        UNIT_ARITH = 2'd0,
        UNIT_SHIFT = 2'd1,
        UNIT_LOGIC = 2'd2,
        UNIT_MUL   = 2'd3
    } alu_unit_e;

    // one flat code per operation after decode
    typedef enum logic [`ALU_OP_W-1:0] {
        OP_NOP, OP_ADD, OP_INC, OP_SUB, OP_DEC,
        OP_SHL, OP_SHR, OP_SAR,
        OP_AND, OP_OR, OP_XOR, OP_SWAP, OP_NOT,
        OP_MUL
    } alu_op_e;

    typedef struct packed {
        logic zero;
        logic neg;
        logic carry;
        logic ovf;
    } alu_flags_t;

    typedef struct packed {
        alu_op_e                op;
        logic [`ALU_WIDTH-1:0]  a;
        logic [`ALU_WIDTH-1:0]  b;
    } alu_cmd_t;

    // hi is only nonzero for multiply
    typedef struct packed {
        logic [`ALU_WIDTH-1:0]  lo;
        logic [`ALU_WIDTH-1:0]  hi;
        alu_flags_t             flags;
    } alu_res_t;

endpackage

`default_nettype wire

// File: hdl/alu_stream_if.sv
`timescale 1ns/1ps
`default_nettype none

// valid/ready stream where the source holds data until taken
interface alu_stream_if #(
    parameter type payload_t = logic
);

    logic     valid;
    logic     ready;
    payload_t data;

    modport source (
        output valid,
        output data,
        input  ready
    );

    modport sink (
        input  valid,
        input  data,
        output ready
    );

endinterface

`default_nettype wire

// File: hdl/alu_arith.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_params.svh"

module alu_arith (
    input  alu_pkg::alu_op_e           op,
    input  wire logic [`ALU_WIDTH-1:0] a,
    input  wire logic [`ALU_WIDTH-1:0] b,
    output logic [`ALU_WIDTH-1:0]      sum,
    output logic                       carry,
    output logic                       ovf
);

    import alu_pkg::*;

    localparam int W = `ALU_WIDTH;

    logic [W-1:0] opnd;
    logic         is_sub;
    logic [W:0]   ext;

    // inc and dec reuse the adder with a constant one
    always_comb
    begin
        opnd   = '0;
        is_sub = 1'b0;
        case (op)
            OP_ADD: opnd = b;
            OP_INC: opnd = W'(1);
            OP_SUB:
            begin
                opnd   = b;
                is_sub = 1'b1;
            end
            OP_DEC:
            begin
                opnd   = W'(1);
                is_sub = 1'b1;
            end
            default: opnd = '0;
        endcase
    end

    // bit W is the carry on add and the borrow on subtract
    assign ext   = is_sub ? ({1'b0, a} - {1'b0, opnd}) : ({1'b0, a} + {1'b0, opnd});
    assign sum   = ext[W-1:0];
    assign carry = ext[W];

    // signed overflow where the operand sign compare flips for subtract
    assign ovf = ((a[W-1] ^ opnd[W-1]) == is_sub) && (sum[W-1] != a[W-1]);

endmodule

`default_nettype wire

// File: hdl/alu_bitwise.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_params.svh"

module alu_bitwise (
    input  alu_pkg::alu_op_e           op,
    input  wire logic [`ALU_WIDTH-1:0] a,
    input  wire logic [`ALU_WIDTH-1:0] b,
    output logic [`ALU_WIDTH-1:0]      result,
    output logic                       carry
);

    import alu_pkg::*;

    localparam int W = `ALU_WIDTH;

    logic [`ALU_SHAMT_W-1:0] shamt;

    assign shamt = b[`ALU_SHAMT_W-1:0];

    // shifts run one bit wider so the last bit out lands in carry
    always_comb
    begin
        result = '0;
        carry  = 1'b0;
        case (op)
            OP_SHL:
            begin
                {carry, result} = {1'b0, a} << shamt;
            end
            OP_SHR:
            begin
                {result, carry} = {a, 1'b0} >> shamt;
            end
            OP_SAR:
            begin
                {result, carry} = $signed({a, 1'b0}) >>> shamt;
            end
            OP_AND:  result = a & b;
            OP_OR:   result = a | b;
            OP_XOR:  result = a ^ b;
            // exchange the two halves
            OP_SWAP: result = {a[W/2-1:0], a[W-1:W/2]};
            OP_NOT:  result = ~a;
            default:
            begin
                result = '0;
                carry  = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/alu_mult.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_params.svh"

module alu_mult (
    input  wire logic                    clk,
    input  wire logic                    en,
    input  wire logic [`ALU_WIDTH-1:0]   a,
    input  wire logic [`ALU_WIDTH-1:0]   b,
    output logic [2*`ALU_WIDTH-1:0]      product
);

    localparam int H = `ALU_WIDTH / 2;

    logic [2*H-1:0] pp_ll;
    logic [2*H-1:0] pp_lh;
    logic [2*H-1:0] pp_hl;
    logic [2*H-1:0] pp_hh;

    // half width partial products form the first register stage
    always_ff @(posedge clk)
    begin
        if (en)
        begin
            pp_ll <= a[H-1:0] * b[H-1:0];
            pp_lh <= a[H-1:0] * b[2*H-1:H];
            pp_hl <= a[2*H-1:H] * b[H-1:0];
            pp_hh <= a[2*H-1:H] * b[2*H-1:H];
        end
    end

    // cross terms enter at the middle of the abutting outer products
    assign product = {pp_hh, pp_ll}
                   + {{H{1'b0}}, pp_lh, {H{1'b0}}}
                   + {{H{1'b0}}, pp_hl, {H{1'b0}}};

endmodule

`default_nettype wire

// File: hdl/alu_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_params.svh"

module alu_decode (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   cmd_valid,
    output logic                        cmd_ready,
    input  alu_pkg::alu_unit_e          cmd_unit,
    input  wire logic [`ALU_FUNC_W-1:0] cmd_func,
    input  wire logic [`ALU_WIDTH-1:0]  cmd_a,
    input  wire logic [`ALU_WIDTH-1:0]  cmd_b,
    alu_stream_if.source                out
);

    import alu_pkg::*;

    alu_op_e op_dec;

    // unlisted unit/function pairs fall to a nop
    always_comb
    begin
        op_dec = OP_NOP;
        case (cmd_unit)
            UNIT_ARITH:
            begin
                case (cmd_func)
                    3'd0:    op_dec = OP_ADD;
                    3'd1:    op_dec = OP_INC;
                    3'd2:    op_dec = OP_SUB;
                    3'd3:    op_dec = OP_DEC;
                    default: op_dec = OP_NOP;
                endcase
            end
            UNIT_SHIFT:
            begin
                case (cmd_func)
                    3'd0:    op_dec = OP_SHL;
                    3'd1:    op_dec = OP_SHR;
                    3'd2:    op_dec = OP_SAR;
                    default: op_dec = OP_NOP;
                endcase
            end
            UNIT_LOGIC:
            begin
                case (cmd_func)
                    3'd0:    op_dec = OP_AND;
                    3'd1:    op_dec = OP_OR;
                    3'd2:    op_dec = OP_XOR;
                    3'd3:    op_dec = OP_SWAP;
                    3'd4:    op_dec = OP_NOT;
                    default: op_dec = OP_NOP;
                endcase
            end
            UNIT_MUL: op_dec = OP_MUL;
        endcase
    end

    // single slot that can refill in the cycle it drains
    assign cmd_ready = !out.valid || out.ready;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            out.valid <= 1'b0;
        else if (cmd_ready)
            out.valid <= cmd_valid;
    end

    always_ff @(posedge clk)
    begin
        if (cmd_valid && cmd_ready)
            out.data <= '{op: op_dec, a: cmd_a, b: cmd_b};
    end

    // a stalled command must not change under the consumer
    a_hold_stalled: assert property (@(posedge clk) disable iff (!rst_n)
        out.valid && !out.ready |=> out.valid && $stable(out.data));

endmodule

`default_nettype wire

// File: hdl/alu_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_params.svh"

module alu_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = `ALU_FIFO_DEPTH
) (
    input wire logic     clk,
    input wire logic     rst_n,
    alu_stream_if.sink   in,
    alu_stream_if.source out
);

    localparam int             PTR_W = $clog2(DEPTH);
    localparam logic [PTR_W:0] FULL  = (PTR_W + 1)'(DEPTH);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             wr_en;
    logic             rd_en;

    ////////////////////////////////////////////////////////////////////////////
    // handshakes
    ////////////////////////////////////////////////////////////////////////////

    assign in.ready  = (count != FULL);
    assign out.valid = (count != '0);
    assign out.data  = mem[rd_ptr];

    assign wr_en = in.valid && in.ready;
    assign rd_en = out.valid && out.ready;

    ////////////////////////////////////////////////////////////////////////////
    // pointers and occupancy
    ////////////////////////////////////////////////////////////////////////////

    // pointers wrap on their own since DEPTH is a power of two
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (wr_en)
                wr_ptr <= wr_ptr + 1'b1;
            if (rd_en)
                rd_ptr <= rd_ptr + 1'b1;
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (wr_en)
            mem[wr_ptr] <= in.data;
    end

    // a full buffer keeps its write slot, an empty one its read slot
    a_no_write_full: assert property (@(posedge clk) disable iff (!rst_n)
        (count == FULL) |=> $stable(wr_ptr));

    a_no_read_empty: assert property (@(posedge clk) disable iff (!rst_n)
        (count == '0) |=> $stable(rd_ptr));

endmodule

`default_nettype wire

// File: hdl/alu_exec.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_params.svh"

module alu_exec (
    input wire logic     clk,
    input wire logic     rst_n,
    alu_stream_if.sink   in,
    alu_stream_if.source out
);

    import alu_pkg::*;

    localparam int W = `ALU_WIDTH;

    logic             stage_en;
    logic             s1_valid;
    alu_op_e          s1_op;
    logic [W-1:0]     arith_sum;
    logic             arith_carry;
    logic             arith_ovf;
    logic [W-1:0]     bw_res;
    logic             bw_carry;
    logic [W-1:0]     s1_sum;
    logic             s1_arith_carry;
    logic             s1_arith_ovf;
    logic [W-1:0]     s1_bw_res;
    logic             s1_bw_carry;
    logic [2*W-1:0]   product;
    alu_res_t         res_d;

    // whole pipe freezes together while the result is refused
    assign stage_en = !out.valid || out.ready;
    assign in.ready = stage_en;

    ////////////////////////////////////////////////////////////////////////////
    // stage 1 unit evaluation
    ////////////////////////////////////////////////////////////////////////////

    alu_arith arith_inst (
        .op    (in.data.op),
        .a     (in.data.a),
        .b     (in.data.b),
        .sum   (arith_sum),
        .carry (arith_carry),
        .ovf   (arith_ovf)
    );

    alu_bitwise bitwise_inst (
        .op     (in.data.op),
        .a      (in.data.a),
        .b      (in.data.b),
        .result (bw_res),
        .carry  (bw_carry)
    );

    // partial products sit in the stage 1 registers inside the multiplier
    alu_mult mult_inst (
        .clk     (clk),
        .en      (stage_en),
        .a       (in.data.a),
        .b       (in.data.b),
        .product (product)
    );

    always_ff @(posedge clk)
    begin
        if (stage_en)
        begin
            s1_op          <= in.data.op;
            s1_sum         <= arith_sum;
            s1_arith_carry <= arith_carry;
            s1_arith_ovf   <= arith_ovf;
            s1_bw_res      <= bw_res;
            s1_bw_carry    <= bw_carry;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stage 2 select and flags
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        res_d = '0;
        case (s1_op)
            OP_ADD, OP_INC, OP_SUB, OP_DEC:
            begin
                res_d.lo          = s1_sum;
                res_d.flags.carry = s1_arith_carry;
                res_d.flags.ovf   = s1_arith_ovf;
            end
            OP_SHL, OP_SHR, OP_SAR, OP_AND, OP_OR, OP_XOR, OP_SWAP, OP_NOT:
            begin
                res_d.lo          = s1_bw_res;
                res_d.flags.carry = s1_bw_carry;
            end
            OP_MUL:
            begin
                {res_d.hi, res_d.lo} = product;
                res_d.flags.ovf      = |product[2*W-1:W];
            end
            default:
            begin
                res_d.lo = '0;
            end
        endcase
        res_d.flags.zero = ({res_d.hi, res_d.lo} == '0);
        res_d.flags.neg  = (s1_op == OP_MUL) ? res_d.hi[W-1] : res_d.lo[W-1];
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            s1_valid  <= 1'b0;
            out.valid <= 1'b0;
        end
        else if (stage_en)
        begin
            s1_valid  <= in.valid;
            out.valid <= s1_valid;
        end
    end

    always_ff @(posedge clk)
    begin
        if (stage_en)
            out.data <= res_d;
    end

    a_valid_held: assert property (@(posedge clk) disable iff (!rst_n)
        out.valid && !out.ready |=> out.valid);

endmodule

`default_nettype wire

// File: hdl/alu32_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_params.svh"

module alu32_top (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   cmd_valid,
    output logic                        cmd_ready,
    input  wire logic [`ALU_UNIT_W-1:0] cmd_unit,
    input  wire logic [`ALU_FUNC_W-1:0] cmd_func,
    input  wire logic [`ALU_WIDTH-1:0]  cmd_a,
    input  wire logic [`ALU_WIDTH-1:0]  cmd_b,
    output logic                        res_valid,
    input  wire logic                   res_ready,
    output logic [`ALU_WIDTH-1:0]       res_lo,
    output logic [`ALU_WIDTH-1:0]       res_hi,
    output logic                        res_zero,
    output logic                        res_neg,
    output logic                        res_carry,
    output logic                        res_ovf
);

    import alu_pkg::*;

    alu_stream_if #(.payload_t(alu_cmd_t)) cmd_dec_s ();
    alu_stream_if #(.payload_t(alu_cmd_t)) cmd_exe_s ();
    alu_stream_if #(.payload_t(alu_res_t)) res_exe_s ();
    alu_stream_if #(.payload_t(alu_res_t)) res_out_s ();

    ////////////////////////////////////////////////////////////////////////////
    // decode -> command fifo -> execute -> result fifo
    ////////////////////////////////////////////////////////////////////////////

    alu_decode decode_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd_unit  (alu_unit_e'(cmd_unit)),
        .cmd_func  (cmd_func),
        .cmd_a     (cmd_a),
        .cmd_b     (cmd_b),
        .out       (cmd_dec_s)
    );

    alu_fifo #(.payload_t(alu_cmd_t)) cmd_fifo_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .in    (cmd_dec_s),
        .out   (cmd_exe_s)
    );

    alu_exec exec_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .in    (cmd_exe_s),
        .out   (res_exe_s)
    );

    alu_fifo #(.payload_t(alu_res_t)) res_fifo_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .in    (res_exe_s),
        .out   (res_out_s)
    );

    // result stream out to plain ports
    assign res_out_s.ready = res_ready;
    assign res_valid       = res_out_s.valid;
    assign res_lo          = res_out_s.data.lo;
    assign res_hi          = res_out_s.data.hi;
    assign res_zero        = res_out_s.data.flags.zero;
    assign res_neg         = res_out_s.data.flags.neg;
    assign res_carry       = res_out_s.data.flags.carry;
    assign res_ovf         = res_out_s.data.flags.ovf;

endmodule

`default_nettype wire

// File: bench/alu_model.svh
`ifndef ALU_MODEL_SVH
`define ALU_MODEL_SVH

typedef struct packed {
    logic [31:0] lo;
    logic [31:0] hi;
    logic        zero;
    logic        neg;
    logic        carry;
    logic        ovf;
} exp_res_t;

// expected result straight from the unit/function table where unknown pairs stay zero
function automatic exp_res_t expected_result(input logic [1:0] unit, input logic [2:0] func,
                                             input logic [31:0] a, input logic [31:0] b);
    exp_res_t    r;
    logic [32:0] wide;
    logic [31:0] opnd;
    logic [63:0] prod;
    int          n;
    r = '0;
    n = int'(b[4:0]);
    case (unit)
        2'd0:
        begin
            // odd codes use a constant one and codes 2 and 3 subtract
            opnd = func[0] ? 32'd1 : b;
            if (func <= 3'd3 && !func[1])
            begin
                wide    = {1'b0, a} + {1'b0, opnd};
                r.lo    = wide[31:0];
                r.carry = wide[32];
                r.ovf   = (a[31] == opnd[31]) && (r.lo[31] != a[31]);
            end
            else if (func <= 3'd3)
            begin
                r.lo    = a - opnd;
                r.carry = a < opnd;
                r.ovf   = (a[31] != opnd[31]) && (r.lo[31] != a[31]);
            end
        end
        2'd1:
        begin
            if (func == 3'd0)
                r.lo = a << n;
            else if (func == 3'd1)
                r.lo = a >> n;
            else if (func == 3'd2)
                r.lo = (a >> n) | ({32{a[31]}} & ~(32'hffffffff >> n));
            if (n != 0 && func == 3'd0)
                r.carry = a[32-n];
            else if (n != 0 && (func == 3'd1 || func == 3'd2))
                r.carry = a[n-1];
        end
        2'd2:
        begin
            case (func)
                3'd0:    r.lo = a & b;
                3'd1:    r.lo = a | b;
                3'd2:    r.lo = a ^ b;
                3'd3:    r.lo = {a[15:0], a[31:16]};
                3'd4:    r.lo = ~a;
                default: r.lo = 32'd0;
            endcase
        end
        default:
        begin
            prod  = {32'd0, a} * {32'd0, b};
            r.hi  = prod[63:32];
            r.lo  = prod[31:0];
            r.ovf = (r.hi != 32'd0);
        end
    endcase
    r.zero = ({r.hi, r.lo} == 64'd0);
    r.neg  = (unit == 2'd3) ? r.hi[31] : r.lo[31];
    return r;
endfunction

`endif

// File: bench/alu32_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_params.svh"

module alu32_tb;

    localparam int WAIT_LIMIT  = 500;
    localparam int IDLE_CYCLES = 40;

    logic                   clk;
    logic                   rst_n;
    logic                   cmd_valid;
    logic                   cmd_ready;
    logic [`ALU_UNIT_W-1:0] cmd_unit;
    logic [`ALU_FUNC_W-1:0] cmd_func;
    logic [`ALU_WIDTH-1:0]  cmd_a;
    logic [`ALU_WIDTH-1:0]  cmd_b;
    logic                   res_valid;
    logic                   res_ready;
    logic [`ALU_WIDTH-1:0]  res_lo;
    logic [`ALU_WIDTH-1:0]  res_hi;
    logic                   res_zero;
    logic                   res_neg;
    logic                   res_carry;
    logic                   res_ovf;

    `include "alu_model.svh"

    exp_res_t    pending[$];
    logic [31:0] edge_vals [4] = '{32'h0, 32'h7fffffff, 32'h80000000, 32'hffffffff};

    alu32_top alu32_top_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd_unit  (cmd_unit),
        .cmd_func  (cmd_func),
        .cmd_a     (cmd_a),
        .cmd_b     (cmd_b),
        .res_valid (res_valid),
        .res_ready (res_ready),
        .res_lo    (res_lo),
        .res_hi    (res_hi),
        .res_zero  (res_zero),
        .res_neg   (res_neg),
        .res_carry (res_carry),
        .res_ovf   (res_ovf)
    );

    always #20 clk = ~clk;

    task automatic fail_and_stop();
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_equal(input string name, input logic [63:0] got,
                               input logic [63:0] want);
        if (got !== want)
        begin
            $display("error: %s got 0x%0h expected 0x%0h", name, got, want);
            fail_and_stop();
        end
    endtask

    // edge values about a quarter of the time
    function automatic logic [31:0] pick_operand();
        if ($urandom % 4 == 0)
            return edge_vals[$urandom % 4];
        return $urandom;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // command side
    ////////////////////////////////////////////////////////////////////////////

    task automatic send_cmd(input logic [1:0] unit, input logic [2:0] func,
                            input logic [31:0] a, input logic [31:0] b);
        int gap;
        int waited;
        gap = $urandom % 4;
        repeat (gap)
        begin
            @(negedge clk);
            cmd_valid = 1'b0;
        end
        @(negedge clk);
        cmd_valid = 1'b1;
        cmd_unit  = unit;
        cmd_func  = func;
        cmd_a     = a;
        cmd_b     = b;
        waited    = 0;
        // ready only moves on the rising edge, so it is settled here
        while (!cmd_ready)
        begin
            if (waited == WAIT_LIMIT)
            begin
                $display("timeout: cmd_ready stayed low for %0d cycles", WAIT_LIMIT);
                fail_and_stop();
            end
            @(negedge clk);
            waited++;
        end
        pending.push_back(expected_result(unit, func, a, b));
        @(posedge clk);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // result side checked in the half cycle before the taking edge
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clk)
    begin
        exp_res_t want;
        if (rst_n)
        begin
            res_ready = ($urandom % 100) >= 30;
            if (res_valid && res_ready)
            begin
                if (pending.size() == 0)
                begin
                    $display("a result came out with no command waiting for it");
                    fail_and_stop();
                end
                want = pending.pop_front();
                check_equal("res_lo", 64'(res_lo), 64'(want.lo));
                check_equal("res_hi", 64'(res_hi), 64'(want.hi));
                check_equal("res_zero", 64'(res_zero), 64'(want.zero));
                check_equal("res_neg", 64'(res_neg), 64'(want.neg));
                check_equal("res_carry", 64'(res_carry), 64'(want.carry));
                check_equal("res_ovf", 64'(res_ovf), 64'(want.ovf));
            end
        end
    end

    initial
    begin
        int waited;
        clk       = 1'b0;
        rst_n     = 1'b0;
        cmd_valid = 1'b0;
        cmd_unit  = '0;
        cmd_func  = '0;
        cmd_a     = '0;
        cmd_b     = '0;
        res_ready = 1'b0;
        void'($urandom(63353));
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_equal("cmd_ready", 64'(cmd_ready), 64'(1'b1));
        check_equal("res_valid", 64'(res_valid), 64'(1'b0));

        // arithmetic over all edge pairings then random operands
        for (int f = 0; f < 4; f++)
        begin
            foreach (edge_vals[i])
                foreach (edge_vals[j])
                    send_cmd(2'd0, 3'(f), edge_vals[i], edge_vals[j]);
            repeat (20)
                send_cmd(2'd0, 3'(f), pick_operand(), pick_operand());
        end
        for (int f = 0; f < 5; f++)
            repeat (20)
                send_cmd(2'd2, 3'(f), pick_operand(), pick_operand());
        // every shift amount with random upper bits of b
        for (int f = 0; f < 3; f++)
            for (int n = 0; n < 32; n++)
                send_cmd(2'd1, 3'(f), pick_operand(),
                         (pick_operand() & 32'hffffffe0) | 32'(n));
        foreach (edge_vals[i])
            foreach (edge_vals[j])
                send_cmd(2'd3, 3'($urandom), edge_vals[i], edge_vals[j]);
        repeat (40)
            send_cmd(2'd3, 3'($urandom), pick_operand(), pick_operand());
        // full code sweep puts the no-ops between listed operations
        repeat (2)
            for (int u = 0; u < 3; u++)
                for (int f = 0; f < 8; f++)
                    send_cmd(2'(u), 3'(f), pick_operand(), pick_operand());
        repeat (300)
            send_cmd(2'($urandom), 3'($urandom), pick_operand(), pick_operand());

        @(negedge clk);
        cmd_valid = 1'b0;
        waited    = 0;
        while (pending.size() != 0)
        begin
            if (waited == WAIT_LIMIT)
            begin
                $display("timeout: %0d results never came out", pending.size());
                fail_and_stop();
            end
            @(negedge clk);
            waited++;
        end
        repeat (IDLE_CYCLES)
        begin
            @(negedge clk);
            check_equal("res_valid", 64'(res_valid), 64'(1'b0));
        end

        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+hdl
+incdir+bench
hdl/alu_pkg.sv
hdl/alu_stream_if.sv
hdl/alu_arith.sv
hdl/alu_bitwise.sv
hdl/alu_mult.sv
hdl/alu_decode.sv
hdl/alu_fifo.sv
hdl/alu_exec.sv
hdl/alu32_top.sv
bench/alu32_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the ALU testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module alu32_tb -f all.f \
    --Mdir obj_dir -o alu32_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/alu32_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit $status
fi

exit 0
